// ==== hw/sl_credit_tx.sv ====
module sl_credit_tx #(
  parameter int RX_DEPTH = 4,
  parameter int DATA_W_P = sl_pkg::DATA_W
) (
  input  logic                      i_serial_link_0,
  input  logic                      i_rst_n,
  input  logic                      i_tx_valid,
  input  logic [DATA_W_P-1:0]       i_tx_data,
  input  logic [sl_pkg::CRED_W-1:0] i_peer_credits,
  input  logic [sl_pkg::CRED_W-1:0] i_cred_return,
  output logic                      o_tx_accept,
  output logic                      o_cred_taken_ack,
  output sl_pkg::sl_flit_t          o_phy_flit,
  output logic                      o_stalled,
  output logic                      o_cred_only_sent
);

  localparam int CW    = sl_pkg::CRED_W;
  localparam int PAY_W = sl_pkg::DATA_W;
  // peer buffer starts empty, so all of its slots are ours
  localparam logic [CW-1:0] INIT_CRED = CW'(RX_DEPTH);
  localparam logic [CW-1:0] HALF_CRED = CW'(RX_DEPTH / 2);

  logic [CW-1:0]         rem_cred_q;
  logic [CW-1:0]         rem_cred_d;
  logic                  send_data;
  logic                  send_cred;
  sl_pkg::sl_flit_body_u body_d;
  sl_pkg::sl_flit_body_u body_q;
  logic                  cred_only_q;
  logic                  valid_q;
  logic                  accept_q;

  // ========================================
  // framing decision
  // ========================================

  // data wins whenever the peer has room
  always_comb begin
    send_data = i_tx_valid && (rem_cred_q != '0);
    send_cred = !send_data &&
                ((i_cred_return >= HALF_CRED) ||
                 ((i_cred_return != '0) && !i_tx_valid));
  end

  // owed credits ride along with whatever goes out
  always_comb begin
    if (send_cred) begin
      body_d.cred.credits = i_cred_return;
      body_d.cred.rsvd    = '0;
    end else begin
      body_d.data.credits = i_cred_return;
      body_d.data.payload = PAY_W'(i_tx_data);
    end
  end

  assign o_cred_taken_ack = send_data || send_cred;

  // returned slots in, one slot out per data flit
  assign rem_cred_d = rem_cred_q + i_peer_credits - CW'(send_data);

  // ========================================
  // flit register
  // ========================================

  always_ff @(posedge i_serial_link_0 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      rem_cred_q <= INIT_CRED;
      valid_q    <= 1'b0;
      accept_q   <= 1'b0;
    end else begin
      rem_cred_q <= rem_cred_d;
      valid_q    <= send_data || send_cred;
      accept_q   <= send_data;
    end
  end

  always_ff @(posedge i_serial_link_0) begin
    body_q      <= body_d;
    cred_only_q <= send_cred;
  end

  always_comb begin
    o_phy_flit.cred_only = cred_only_q;
    o_phy_flit.body      = body_q;
    o_phy_flit.valid     = valid_q;
  end

  assign o_tx_accept = accept_q;

  // event bits for the counters
  assign o_stalled        = i_tx_valid && (rem_cred_q == '0);
  assign o_cred_only_sent = valid_q && cred_only_q;

endmodule

// ==== hw/sl_data_link.sv ====
module sl_data_link #(
  parameter int RX_DEPTH = 4,
  parameter int DATA_W_P = sl_pkg::DATA_W
) (
  input  logic                i_serial_link_0,
  input  logic                i_rst_n,
  input  logic                i_tx_valid,
  input  logic [DATA_W_P-1:0] i_tx_data,
  input  logic                i_rx_pop,
  input  sl_pkg::sl_flit_t    i_phy_flit,
  output logic                o_tx_accept,
  output logic                o_rx_valid,
  output logic [DATA_W_P-1:0] o_rx_data,
  output sl_pkg::sl_flit_t    o_phy_flit,
  output sl_pkg::sl_events_t  o_events
);

  logic [sl_pkg::CRED_W-1:0] peer_credits;
  logic [sl_pkg::CRED_W-1:0] cred_return;
  logic                      cred_taken_ack;
  logic                      stalled;
  logic                      cred_only_sent;

  // transmit side
  sl_credit_tx #(
    .RX_DEPTH (RX_DEPTH),
    .DATA_W_P (DATA_W_P)
  ) u_credit_tx (
    .i_serial_link_0  (i_serial_link_0),
    .i_rst_n          (i_rst_n),
    .i_tx_valid       (i_tx_valid),
    .i_tx_data        (i_tx_data),
    .i_peer_credits   (peer_credits),
    .i_cred_return    (cred_return),
    .o_tx_accept      (o_tx_accept),
    .o_cred_taken_ack (cred_taken_ack),
    .o_phy_flit       (o_phy_flit),
    .o_stalled        (stalled),
    .o_cred_only_sent (cred_only_sent)
  );

  // receive side
  sl_rx_buffer #(
    .RX_DEPTH (RX_DEPTH),
    .DATA_W_P (DATA_W_P)
  ) u_rx_buffer (
    .i_serial_link_0  (i_serial_link_0),
    .i_rst_n          (i_rst_n),
    .i_phy_flit       (i_phy_flit),
    .i_rx_pop         (i_rx_pop),
    .i_cred_taken_ack (cred_taken_ack),
    .o_rx_valid       (o_rx_valid),
    .o_rx_data        (o_rx_data),
    .o_peer_credits   (peer_credits),
    .o_cred_return    (cred_return)
  );

  // events seen on both phy directions
  always_comb begin
    o_events.tx_valid       = o_phy_flit.valid;
    o_events.rx_valid       = i_phy_flit.valid;
    o_events.cred_only_sent = cred_only_sent;
    o_events.stalled        = stalled;
    o_events.spare          = 1'b0;
  end

endmodule

// ==== hw/sl_link_pair_top.sv ====
module sl_link_pair_top #(
  parameter int RX_DEPTH = 4,
  parameter int DATA_W_P = sl_pkg::DATA_W
) (
  input  logic                i_serial_link_0,
  input  logic                i_rst_n,
  input  logic                i_a_tx_valid,
  input  logic [DATA_W_P-1:0] i_a_tx_data,
  input  logic                i_a_rx_pop,
  input  logic                i_b_tx_valid,
  input  logic [DATA_W_P-1:0] i_b_tx_data,
  input  logic                i_b_rx_pop,
  output logic                o_a_tx_accept,
  output logic                o_a_rx_valid,
  output logic [DATA_W_P-1:0] o_a_rx_data,
  output logic                o_b_tx_accept,
  output logic                o_b_rx_valid,
  output logic [DATA_W_P-1:0] o_b_rx_data,
  output sl_pkg::sl_perf_t    o_a_perf,
  output sl_pkg::sl_perf_t    o_b_perf
);

  // phy wires, crossed between the two endpoints
  sl_pkg::sl_flit_t   flit_a2b;
  sl_pkg::sl_flit_t   flit_b2a;
  sl_pkg::sl_events_t events_a;
  sl_pkg::sl_events_t events_b;

  // ========================================
  // endpoints
  // ========================================

  sl_data_link #(
    .RX_DEPTH (RX_DEPTH),
    .DATA_W_P (DATA_W_P)
  ) link_a (
    .i_serial_link_0 (i_serial_link_0),
    .i_rst_n         (i_rst_n),
    .i_tx_valid      (i_a_tx_valid),
    .i_tx_data       (i_a_tx_data),
    .i_rx_pop        (i_a_rx_pop),
    .i_phy_flit      (flit_b2a),
    .o_tx_accept     (o_a_tx_accept),
    .o_rx_valid      (o_a_rx_valid),
    .o_rx_data       (o_a_rx_data),
    .o_phy_flit      (flit_a2b),
    .o_events        (events_a)
  );

  sl_data_link #(
    .RX_DEPTH (RX_DEPTH),
    .DATA_W_P (DATA_W_P)
  ) link_b (
    .i_serial_link_0 (i_serial_link_0),
    .i_rst_n         (i_rst_n),
    .i_tx_valid      (i_b_tx_valid),
    .i_tx_data       (i_b_tx_data),
    .i_rx_pop        (i_b_rx_pop),
    .i_phy_flit      (flit_a2b),
    .o_tx_accept     (o_b_tx_accept),
    .o_rx_valid      (o_b_rx_valid),
    .o_rx_data       (o_b_rx_data),
    .o_phy_flit      (flit_b2a),
    .o_events        (events_b)
  );

  // ========================================
  // counter blocks
  // ========================================

  sl_perf_counters perf_a (
    .i_serial_link_0 (i_serial_link_0),
    .i_rst_n         (i_rst_n),
    .i_events        (events_a),
    .o_perf          (o_a_perf)
  );

  sl_perf_counters perf_b (
    .i_serial_link_0 (i_serial_link_0),
    .i_rst_n         (i_rst_n),
    .i_events        (events_b),
    .o_perf          (o_b_perf)
  );

endmodule

// ==== hw/sl_perf_counters.sv ====
module sl_perf_counters (
  input  logic               i_serial_link_0,
  input  logic               i_rst_n,
  input  sl_pkg::sl_events_t i_events,
  output sl_pkg::sl_perf_t   o_perf
);

  localparam int CNT_W = sl_pkg::CNT_W;

  sl_pkg::sl_perf_t perf_q;

  // add one when the event is set
  function automatic logic [CNT_W-1:0] bump(
    input logic [CNT_W-1:0] cnt,
    input logic             en
  );
    bump = cnt + CNT_W'(en);
  endfunction

  // ========================================
  // benchmarking counters
  // ========================================

  // each count lands on the edge closing the cycle it describes
  always_ff @(posedge i_serial_link_0 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      perf_q <= '0;
    end else begin
      perf_q.number_cycles   <= bump(perf_q.number_cycles, 1'b1);
      perf_q.valid_to_phys   <= bump(perf_q.valid_to_phys, i_events.tx_valid);
      perf_q.valid_from_phys <= bump(perf_q.valid_from_phys, i_events.rx_valid);
      perf_q.cred_only_sent  <= bump(perf_q.cred_only_sent, i_events.cred_only_sent);
      perf_q.stalled_cycles  <= bump(perf_q.stalled_cycles, i_events.stalled);
    end
  end

  assign o_perf = perf_q;

endmodule

// ==== hw/sl_pkg.sv ====
package sl_pkg;

  // ========================================
  // widths
  // ========================================

  // payload bits carried by one data flit
  localparam int DATA_W = 16;
  // credit field, enough for up to 15 receive slots
  localparam int CRED_W = 4;
  // width of every performance counter
  localparam int CNT_W = 32;

  // ========================================
  // flit format
  // ========================================

  // data view of the flit body
  typedef struct packed {
    logic [CRED_W-1:0] credits;
    logic [DATA_W-1:0] payload;
  } sl_data_flit_t;

  // credit-only view, payload slot kept at zero
  typedef struct packed {
    logic [CRED_W-1:0] credits;
    logic [DATA_W-1:0] rsvd;
  } sl_cred_flit_t;

  // same body word, read as data or credit-only depending on the flag
  typedef union packed {
    sl_data_flit_t data;
    sl_cred_flit_t cred;
  } sl_flit_body_u;

  // word on the physical side, one per cycle
  typedef struct packed {
    logic          cred_only;
    sl_flit_body_u body;
    logic          valid;
  } sl_flit_t;

  // ========================================
  // benchmarking
  // ========================================

  // per-cycle event bits of one endpoint
  typedef struct packed {
    logic tx_valid;
    logic rx_valid;
    logic cred_only_sent;
    logic stalled;
    logic spare;
  } sl_events_t;

  typedef struct packed {
    logic [CNT_W-1:0] number_cycles;
    logic [CNT_W-1:0] valid_to_phys;
    logic [CNT_W-1:0] valid_from_phys;
    logic [CNT_W-1:0] cred_only_sent;
    logic [CNT_W-1:0] stalled_cycles;
  } sl_perf_t;

endpackage

// ==== hw/sl_rx_buffer.sv ====
module sl_rx_buffer #(
  parameter int RX_DEPTH = 4,
  parameter int DATA_W_P = sl_pkg::DATA_W
) (
  input  logic                      i_serial_link_0,
  input  logic                      i_rst_n,
  input  sl_pkg::sl_flit_t          i_phy_flit,
  input  logic                      i_rx_pop,
  input  logic                      i_cred_taken_ack,
  output logic                      o_rx_valid,
  output logic [DATA_W_P-1:0]       o_rx_data,
  output logic [sl_pkg::CRED_W-1:0] o_peer_credits,
  output logic [sl_pkg::CRED_W-1:0] o_cred_return
);

  localparam int CW    = sl_pkg::CRED_W;
  localparam int PTR_W = (RX_DEPTH > 1) ? $clog2(RX_DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(RX_DEPTH - 1);

  logic [DATA_W_P-1:0]   mem [RX_DEPTH];
  logic [PTR_W-1:0]      wr_ptr_q;
  logic [PTR_W-1:0]      rd_ptr_q;
  logic [CW-1:0]         count_q;
  logic [CW-1:0]         owed_q;
  sl_pkg::sl_flit_body_u body;
  logic                  wr_en;
  logic                  pop_ok;

  // circular index, depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_slot(input logic [PTR_W-1:0] ptr);
    if (ptr == LAST_SLOT) begin
      next_slot = '0;
    end else begin
      next_slot = ptr + PTR_W'(1);
    end
  endfunction

  // ========================================
  // incoming flit decode
  // ========================================

  assign body = i_phy_flit.body;

  always_comb begin
    o_peer_credits = '0;
    wr_en          = 1'b0;
    if (i_phy_flit.valid) begin
      // credit field sits at the same place in both views
      o_peer_credits = body.cred.credits;
      wr_en          = !i_phy_flit.cred_only;
    end
  end

  // ========================================
  // fifo and credit return
  // ========================================

  // a pop on an empty buffer is ignored
  assign pop_ok = i_rx_pop && o_rx_valid;

  always_ff @(posedge i_serial_link_0 or negedge i_rst_n) begin
    if (!i_rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
      owed_q   <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= next_slot(wr_ptr_q);
      end
      if (pop_ok) begin
        rd_ptr_q <= next_slot(rd_ptr_q);
      end
      count_q <= count_q + CW'(wr_en) - CW'(pop_ok);
      // framer took the owed count, keep only this cycle's pop
      if (i_cred_taken_ack) begin
        owed_q <= CW'(pop_ok);
      end else begin
        owed_q <= owed_q + CW'(pop_ok);
      end
    end
  end

  always_ff @(posedge i_serial_link_0) begin
    if (wr_en) begin
      mem[wr_ptr_q] <= DATA_W_P'(body.data.payload);
    end
  end

  assign o_rx_valid    = (count_q != '0);
  assign o_rx_data     = mem[rd_ptr_q];
  assign o_cred_return = owed_q;

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build the testbench with Verilator, run it, and judge by the pass line
verilator --binary --timing --assert --timescale 1ns/100ps \
  --top-module tb_sl_link_pair -f serial_link_perf.f -o sim_tb || exit 1
out=$(./obj_dir/sim_tb +verilator+error+limit+100 2>&1)
echo "$out"
echo "$out" | grep -qx "Testbench passed" && echo "run ok" || { echo "run failed"; exit 1; }

// ==== serial_link_perf.f ====
hw/sl_pkg.sv
hw/sl_credit_tx.sv
hw/sl_rx_buffer.sv
hw/sl_data_link.sv
hw/sl_perf_counters.sv
hw/sl_link_pair_top.sv
tb/tb_clock_gen.sv
tb/sl_link_props.sv
tb/tb_sl_link_pair.sv

// ==== tb/sl_link_props.sv ====
module sl_link_props #(
  parameter int RX_DEPTH = 4,
  parameter int DATA_W_P = sl_pkg::DATA_W
) (
  input logic                            i_serial_link_0,
  input logic                            i_rst_n,
  // index 0 is endpoint a, index 1 is endpoint b
  input logic [1:0]                      i_tx_valid,
  input logic [1:0]                      i_tx_accept,
  input logic [1:0][sl_pkg::CRED_W-1:0]  i_rem_cred,
  input logic [1:0]                      i_wr_en,
  input logic [1:0][sl_pkg::CRED_W-1:0]  i_fill,
  input logic [1:0]                      i_rx_valid,
  input logic [1:0]                      i_rx_pop,
  input logic [1:0][DATA_W_P-1:0]        i_rx_data,
  input sl_pkg::sl_perf_t                i_a_perf,
  input sl_pkg::sl_perf_t                i_b_perf
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int CW = sl_pkg::CRED_W;
  localparam logic [CW-1:0] DEPTH_C = CW'(RX_DEPTH);

  int unsigned fail_count = 0;

  for (genvar e = 0; e < 2; e++) begin : g_ep
    // accept pulse follows a cycle with the word offered
    assert property (@(posedge i_serial_link_0) disable iff (!i_rst_n)
      i_tx_accept[e] |-> $past(i_tx_valid[e]))
    else begin
      $error("accept pulse without valid on endpoint %0d", e);
      fail_count++;
    end

    assert property (@(posedge i_serial_link_0) disable iff (!i_rst_n)
      i_rem_cred[e] <= DEPTH_C)
    else begin
      $error("remote credits above buffer depth on endpoint %0d", e);
      fail_count++;
    end

    // overflow would mean a flit went out without credit
    assert property (@(posedge i_serial_link_0) disable iff (!i_rst_n)
      i_wr_en[e] |-> (i_fill[e] != DEPTH_C))
    else begin
      $error("receive buffer written while full on endpoint %0d", e);
      fail_count++;
    end

    assert property (@(posedge i_serial_link_0) disable iff (!i_rst_n)
      (i_rx_valid[e] && !i_rx_pop[e]) |=> $stable(i_rx_data[e]))
    else begin
      $error("receive head changed without pop on endpoint %0d", e);
      fail_count++;
    end
  end

  // no disable here, this one only looks at reset
  assert property (@(posedge i_serial_link_0)
    !i_rst_n |-> ((i_a_perf == '0) && (i_b_perf == '0)))
  else begin
    $error("performance counters nonzero during reset");
    fail_count++;
  end

endmodule

bind sl_link_pair_top sl_link_props #(
  .RX_DEPTH (RX_DEPTH),
  .DATA_W_P (DATA_W_P)
) u_props (
  .i_serial_link_0 (i_serial_link_0),
  .i_rst_n         (i_rst_n),
  .i_tx_valid      ({i_b_tx_valid, i_a_tx_valid}),
  .i_tx_accept     ({o_b_tx_accept, o_a_tx_accept}),
  .i_rem_cred      ({link_b.u_credit_tx.rem_cred_q, link_a.u_credit_tx.rem_cred_q}),
  .i_wr_en         ({link_b.u_rx_buffer.wr_en, link_a.u_rx_buffer.wr_en}),
  .i_fill          ({link_b.u_rx_buffer.count_q, link_a.u_rx_buffer.count_q}),
  .i_rx_valid      ({o_b_rx_valid, o_a_rx_valid}),
  .i_rx_pop        ({i_b_rx_pop, i_a_rx_pop}),
  .i_rx_data       ({o_b_rx_data, o_a_rx_data}),
  .i_a_perf        (o_a_perf),
  .i_b_perf        (o_b_perf)
);

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 2
) (
  output logic o_clk,
  output logic o_rst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    o_clk = 1'b0;
    forever #(PERIOD_NS / 2) o_clk = ~o_clk;
  end

  // brief high level first so the falling reset edge reaches the async flops
  initial begin
    o_rst_n = 1'b1;
    #1;
    o_rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge o_clk);
    @(negedge o_clk);
    o_rst_n = 1'b1;
  end

endmodule

// ==== tb/tb_sl_link_pair.sv ====
module tb_sl_link_pair;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RX_DEPTH = 4;
  localparam int DATA_W   = sl_pkg::DATA_W;
  localparam int WAIT_MAX = 400;

  logic              clk;
  logic              rst_n;
  logic              a_tx_valid;
  logic [DATA_W-1:0] a_tx_data;
  logic              a_rx_pop;
  logic              b_tx_valid;
  logic [DATA_W-1:0] b_tx_data;
  logic              b_rx_pop;
  logic              a_tx_accept;
  logic              a_rx_valid;
  logic [DATA_W-1:0] a_rx_data;
  logic              b_tx_accept;
  logic              b_rx_valid;
  logic [DATA_W-1:0] b_rx_data;
  sl_pkg::sl_perf_t  a_perf;
  sl_pkg::sl_perf_t  b_perf;

  // words waiting at each sender, and words owed to each receiver in order
  logic [DATA_W-1:0] a_send_q[$];
  logic [DATA_W-1:0] b_send_q[$];
  logic [DATA_W-1:0] a_expect_q[$];
  logic [DATA_W-1:0] b_expect_q[$];

  logic [31:0] lcg_state  = 32'hbfd0;
  logic [31:0] edge_count = '0;
  int          a_accepts  = 0;
  int          b_accepts  = 0;
  int          a_pops     = 0;
  int          b_pops     = 0;
  // 0 never pop, 1 random, 2 every cycle with data
  int          pop_mode_a = 0;
  int          pop_mode_b = 0;
  int          test_errs  = 0;
  int          tests_passed = 0;
  int          tests_failed = 0;
  bit          timed_out  = 1'b0;
  string       cur_test   = "";

  tb_clock_gen #(
    .PERIOD_NS    (8),
    .RESET_CYCLES (2)
  ) clk_gen (
    .o_clk   (clk),
    .o_rst_n (rst_n)
  );

  sl_link_pair_top #(
    .RX_DEPTH (RX_DEPTH),
    .DATA_W_P (DATA_W)
  ) dut0 (
    .i_serial_link_0 (clk),
    .i_rst_n         (rst_n),
    .i_a_tx_valid    (a_tx_valid),
    .i_a_tx_data     (a_tx_data),
    .i_a_rx_pop      (a_rx_pop),
    .i_b_tx_valid    (b_tx_valid),
    .i_b_tx_data     (b_tx_data),
    .i_b_rx_pop      (b_rx_pop),
    .o_a_tx_accept   (a_tx_accept),
    .o_a_rx_valid    (a_rx_valid),
    .o_a_rx_data     (a_rx_data),
    .o_b_tx_accept   (b_tx_accept),
    .o_b_rx_valid    (b_rx_valid),
    .o_b_rx_data     (b_rx_data),
    .o_a_perf        (a_perf),
    .o_b_perf        (b_perf)
  );

  // rising edges out of reset, the reference for number_cycles
  always @(posedge clk) begin
    if (rst_n) begin
      edge_count <= edge_count + 32'd1;
    end
  end

  // ========================================
  // helpers
  // ========================================

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [DATA_W-1:0] next_word();
    logic [31:0] r;
    r = lcg_next();
    return r[31:32-DATA_W];
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual == expected) else begin
      $display("FAIL %s %s expected %0h actual %0h", cur_test, name, expected, actual);
      test_errs++;
    end
  endtask

  task automatic check_true(input logic ok, input string what);
    assert (ok) else begin
      $display("%s: %s", cur_test, what);
      test_errs++;
    end
  endtask

  // one clock of user-side behaviour, everything driven on the falling edge
  task automatic tick();
    logic [31:0] r;
    @(negedge clk);
    if (a_tx_accept) begin
      a_accepts++;
      if (a_send_q.size() != 0) b_expect_q.push_back(a_send_q.pop_front());
    end
    if (b_tx_accept) begin
      b_accepts++;
      if (b_send_q.size() != 0) a_expect_q.push_back(b_send_q.pop_front());
    end
    r = lcg_next();
    a_rx_pop = a_rx_valid && (pop_mode_a == 2 || (pop_mode_a == 1 && r[7]));
    b_rx_pop = b_rx_valid && (pop_mode_b == 2 || (pop_mode_b == 1 && r[23]));
    if (a_rx_pop) begin
      a_pops++;
      check_true(a_expect_q.size() != 0, "endpoint a delivered a word never sent");
      if (a_expect_q.size() != 0) begin
        check_value("rx_data_at_a", 32'(a_expect_q.pop_front()), 32'(a_rx_data));
      end
    end
    if (b_rx_pop) begin
      b_pops++;
      check_true(b_expect_q.size() != 0, "endpoint b delivered a word never sent");
      if (b_expect_q.size() != 0) begin
        check_value("rx_data_at_b", 32'(b_expect_q.pop_front()), 32'(b_rx_data));
      end
    end
    a_tx_valid = (a_send_q.size() != 0);
    a_tx_data  = a_tx_valid ? a_send_q[0] : '0;
    b_tx_valid = (b_send_q.size() != 0);
    b_tx_data  = b_tx_valid ? b_send_q[0] : '0;
  endtask

  task automatic wait_accepts(input int a_target, input int b_target);
    int guard;
    guard = 0;
    while ((a_accepts < a_target || b_accepts < b_target) && !timed_out) begin
      tick();
      guard++;
      if (guard > WAIT_MAX) begin
        $display("%s: timed out waiting for words to be accepted", cur_test);
        timed_out = 1'b1;
        test_errs++;
      end
    end
  endtask

  task automatic wait_drained();
    int guard;
    guard = 0;
    while ((a_expect_q.size() != 0 || b_expect_q.size() != 0 || a_rx_valid || b_rx_valid)
           && !timed_out) begin
      tick();
      guard++;
      if (guard > WAIT_MAX) begin
        $display("%s: timed out waiting for receive buffers to drain", cur_test);
        timed_out = 1'b1;
        test_errs++;
      end
    end
  endtask

  task automatic begin_test(input string name);
    cur_test  = name;
    test_errs = 0;
  endtask

  task automatic end_test();
    if (test_errs == 0) begin
      tests_passed++;
      $display("test %s: pass", cur_test);
    end else begin
      tests_failed++;
      $display("test %s: fail with %0d errors", cur_test, test_errs);
    end
  endtask

  // ========================================
  // tests
  // ========================================

  task automatic run_order_test();
    int p0;
    begin_test("order");
    p0 = b_pops;
    pop_mode_b = 1;
    for (int i = 0; i < 20; i++) a_send_q.push_back(next_word());
    wait_accepts(a_accepts + 20, b_accepts);
    wait_drained();
    repeat (10) tick();
    check_value("order_pops", 32'd20, 32'(b_pops - p0));
    end_test();
  endtask

  task automatic run_backpressure_test();
    logic [31:0] s0;
    int          acc0;
    int          stalls;
    begin_test("backpressure");
    pop_mode_b = 0;
    s0   = a_perf.stalled_cycles;
    acc0 = a_accepts;
    for (int i = 0; i <= RX_DEPTH; i++) a_send_q.push_back(next_word());
    wait_accepts(acc0 + RX_DEPTH, b_accepts);
    stalls = a_tx_valid ? 1 : 0;
    for (int i = 0; i < 30; i++) begin
      tick();
      if (a_tx_valid) stalls++;
    end
    check_value("backpressure_accepts", 32'(RX_DEPTH), 32'(a_accepts - acc0));
    // the extra word is withdrawn, it never got credit
    a_send_q.delete();
    tick();
    tick();
    check_value("backpressure_stalls", 32'(stalls), a_perf.stalled_cycles - s0);
    end_test();
  endtask

  task automatic run_credit_return_test();
    logic [31:0] c0;
    logic [31:0] s0;
    int          acc0;
    begin_test("credit_return");
    c0 = b_perf.cred_only_sent;
    pop_mode_b = 2;
    wait_drained();
    repeat (10) tick();
    check_true(b_perf.cred_only_sent > c0, "no credit-only flit came back from b");
    s0   = a_perf.stalled_cycles;
    acc0 = a_accepts;
    for (int i = 0; i < RX_DEPTH; i++) a_send_q.push_back(next_word());
    wait_accepts(acc0 + RX_DEPTH, b_accepts);
    tick();
    check_value("credit_return_stalls", 32'd0, a_perf.stalled_cycles - s0);
    wait_drained();
    end_test();
  endtask

  task automatic run_valid_accounting_test();
    int          pa0;
    int          pb0;
    logic [31:0] va0;
    logic [31:0] ca0;
    logic [31:0] vb0;
    logic [31:0] cb0;
    begin_test("valid_accounting");
    pa0 = a_pops;
    pb0 = b_pops;
    va0 = a_perf.valid_to_phys;
    ca0 = a_perf.cred_only_sent;
    vb0 = b_perf.valid_to_phys;
    cb0 = b_perf.cred_only_sent;
    pop_mode_a = 1;
    pop_mode_b = 1;
    for (int i = 0; i < 12; i++) begin
      a_send_q.push_back(next_word());
      b_send_q.push_back(next_word());
    end
    wait_accepts(a_accepts + 12, b_accepts + 12);
    wait_drained();
    repeat (8) tick();
    check_value("valid_pops_at_a", 32'd12, 32'(a_pops - pa0));
    check_value("valid_pops_at_b", 32'd12, 32'(b_pops - pb0));
    check_value("valid_a_to_b", a_perf.valid_to_phys, b_perf.valid_from_phys);
    check_value("valid_b_to_a", b_perf.valid_to_phys, a_perf.valid_from_phys);
    // a valid flit is either credit-only or one accepted word
    check_value("data_flits_a", 32'd12,
                (a_perf.valid_to_phys - va0) - (a_perf.cred_only_sent - ca0));
    check_value("data_flits_b", 32'd12,
                (b_perf.valid_to_phys - vb0) - (b_perf.cred_only_sent - cb0));
    end_test();
  endtask

  task automatic run_cycle_count_test();
    begin_test("cycle_count");
    tick();
    check_value("cycles_a", edge_count, a_perf.number_cycles);
    check_value("cycles_b", edge_count, b_perf.number_cycles);
    end_test();
  endtask

  // ========================================
  // main sequence
  // ========================================

  initial begin
    int          guard;
    int unsigned prop_fails;
    a_tx_valid = 1'b0;
    a_tx_data  = '0;
    a_rx_pop   = 1'b0;
    b_tx_valid = 1'b0;
    b_tx_data  = '0;
    b_rx_pop   = 1'b0;
    guard      = 0;
    @(negedge clk);
    while (!rst_n && guard < 20) begin
      @(negedge clk);
      guard++;
    end
    if (!rst_n) begin
      $display("reset was never released");
      timed_out = 1'b1;
    end
    if (!timed_out) run_order_test();
    if (!timed_out) run_backpressure_test();
    if (!timed_out) run_credit_return_test();
    if (!timed_out) run_valid_accounting_test();
    if (!timed_out) run_cycle_count_test();
    prop_fails = dut0.u_props.fail_count;
    $display("tests passed %0d, failed %0d, property failures %0d",
             tests_passed, tests_failed, prop_fails);
    if (timed_out || tests_failed != 0 || prop_fails != 0) begin
      $display("Testbench failed");
    end else begin
      $display("Testbench passed");
    end
    $finish;
  end

endmodule
